// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int WAY_NUM        = 2;
    localparam int WAY_ID_WIDTH   = 1;
    localparam int LINE_NUM       = 16;
    localparam int INDEX_WIDTH    = 4;
    localparam int OFFSET_WIDTH   = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int TAG_WIDTH      = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH     = 128;

    // request op codes
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    // controller states
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_MISS    = 3'd2;
    localparam logic [2:0] ST_REPLACE = 3'd3;
    localparam logic [2:0] ST_REFILL  = 3'd4;

    // upper offset bits select the word within the line
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [TAG_WIDTH-1:0]    tag;
            logic [INDEX_WIDTH-1:0]  index;
            logic [OFFSET_WIDTH-1:0] offset;
        } f;
    } cache_addr_t;

endpackage

// ==== src/dcache_req_stage.sv ====
module dcache_req_stage
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   valid,
    input  logic                   op,
    input  cache_addr_t            addr,
    input  logic [3:0]             wstrb,
    input  logic [31:0]            wdata,
    input  logic                   ready,
    output logic                   addr_ok,

    output logic [INDEX_WIDTH-1:0] way_index,
    output logic [TAG_WIDTH-1:0]   way_tag,

    output logic                   lookup_valid,
    output logic                   req_op,
    output cache_addr_t            req_addr,
    output logic [3:0]             req_wstrb,
    output logic [31:0]            req_wdata
);

    assign addr_ok = valid & ready;

    // one lookup cycle follows every accepted request
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_op    <= op;
            req_addr  <= addr;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // incoming index on acceptance so the way read lands in the lookup cycle,
    // otherwise keep the held set addressed for victim capture
    assign way_index = addr_ok ? addr.f.index : req_addr.f.index;

    assign way_tag = req_addr.f.tag;

endmodule

// ==== src/dcache_way.sv ====
module dcache_way
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,

    input  logic [INDEX_WIDTH-1:0] rd_index,
    input  logic [TAG_WIDTH-1:0]   cmp_tag,
    output logic                   hit,
    output logic [LINE_WIDTH-1:0]  rd_line,
    output logic [TAG_WIDTH-1:0]   rd_tag,
    output logic                   rd_dirty,

    input  logic                   we,
    input  logic [INDEX_WIDTH-1:0] wr_index,
    input  logic [TAG_WIDTH-1:0]   wr_tag,
    input  logic [LINE_WIDTH-1:0]  wr_line,
    input  logic                   wr_dirty
);

    logic [TAG_WIDTH-1:0]  tag_mem  [LINE_NUM];
    logic [LINE_WIDTH-1:0] data_mem [LINE_NUM];
    logic [LINE_NUM-1:0]   valid_bits;
    logic [LINE_NUM-1:0]   dirty_bits;
    logic                  valid_q;
    logic                  dirty_q;

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[wr_index] <= 1'b1;
            dirty_bits[wr_index] <= wr_dirty;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        rd_tag  <= tag_mem[rd_index];
        rd_line <= data_mem[rd_index];
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            valid_q <= valid_bits[rd_index];
            dirty_q <= dirty_bits[rd_index];
        end
    end

    assign hit = valid_q && (rd_tag == cmp_tag);

    // victim needs write-back
    assign rd_dirty = valid_q & dirty_q;

endmodule

// ==== src/dcache_ctrl.sv ====
module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   lookup_valid,
    input  logic                   req_op,
    input  cache_addr_t            req_addr,
    input  logic [3:0]             req_wstrb,
    input  logic [31:0]            req_wdata,
    output logic                   ready,

    input  logic [WAY_NUM-1:0]     way_hit,
    input  logic [LINE_WIDTH-1:0]  way_line [WAY_NUM],
    input  logic [TAG_WIDTH-1:0]   way_tag  [WAY_NUM],
    input  logic [WAY_NUM-1:0]     way_dirty,

    output logic [WAY_NUM-1:0]     way_we,
    output logic [INDEX_WIDTH-1:0] wr_index,
    output logic [TAG_WIDTH-1:0]   wr_tag,
    output logic [LINE_WIDTH-1:0]  wr_line,
    output logic                   wr_dirty,

    output logic                   data_ok,
    output logic [31:0]            rdata,

    output logic                   rd_req,
    output logic [31:0]            rd_addr,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  logic [31:0]            ret_data,
    output logic                   wr_req,
    output logic [31:0]            wr_addr,
    output logic [LINE_WIDTH-1:0]  wr_data,
    input  logic                   wr_rdy
);

    logic [2:0]                          state_q;
    logic [2:0]                          state;
    logic                                hit_any;
    logic [WAY_ID_WIDTH-1:0]             hit_id;
    logic [WAY_ID_WIDTH-1:0]             rr_ptr;
    logic [OFFSET_WIDTH-3:0]             word_sel;
    logic [TAG_WIDTH-1:0]                victim_tag;
    logic [LINE_WIDTH-1:0]               victim_line;
    logic [LINE_WIDTH-1:0]               refill_buf;
    logic [LINE_WIDTH-1:0]               refill_line;
    logic [LINE_WIDTH-1:0]               base_line;
    logic [LINE_WIDTH-1:0]               store_line;
    logic [$clog2(WORDS_PER_LINE)-1:0]   beat_cnt;
    logic                                rd_sent;
    logic                                refill_done;

    function automatic logic [LINE_WIDTH-1:0] merge_store(
        input logic [LINE_WIDTH-1:0]   line,
        input logic [OFFSET_WIDTH-3:0] sel,
        input logic [3:0]              strb,
        input logic [31:0]             data
    );
        logic [LINE_WIDTH-1:0] res;
        res = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[sel*32 + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // the lookup cycle is whatever follows an accepted request out of idle
    assign state = (state_q == ST_IDLE && lookup_valid) ? ST_LOOKUP : state_q;

    assign word_sel    = req_addr.f.offset[OFFSET_WIDTH-1:2];
    assign hit_any     = |way_hit;
    assign refill_done = (state == ST_REFILL) && ret_valid && ret_last;

    always_comb begin
        hit_id = '0;
        for (int i = 0; i < WAY_NUM; i++) begin
            if (way_hit[i]) begin
                hit_id = i[WAY_ID_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
        end else begin
            case (state)
                ST_LOOKUP:  state_q <= hit_any ? ST_IDLE : ST_MISS;
                ST_MISS:    state_q <= way_dirty[rr_ptr] ? ST_REPLACE : ST_REFILL;
                ST_REPLACE: state_q <= wr_rdy ? ST_REFILL : ST_REPLACE;
                ST_REFILL:  state_q <= refill_done ? ST_IDLE : ST_REFILL;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rr_ptr <= '0;
        end else if (refill_done) begin
            rr_ptr <= rr_ptr + 1'b1;
        end
    end

    // victim snapshot while the set is still addressed
    always_ff @(posedge clk) begin
        if (state == ST_MISS) begin
            victim_tag  <= way_tag[rr_ptr];
            victim_line <= way_line[rr_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_sent  <= 1'b0;
            beat_cnt <= '0;
        end else if (state != ST_REFILL) begin
            rd_sent  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (rd_rdy) begin
                rd_sent <= 1'b1;
            end
            if (ret_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // current beat folded into the buffer
    always_comb begin
        refill_line = refill_buf;
        refill_line[beat_cnt*32 +: 32] = ret_data;
    end

    always_ff @(posedge clk) begin
        if (state == ST_REFILL && ret_valid) begin
            refill_buf <= refill_line;
        end
    end

    assign base_line  = (state == ST_LOOKUP) ? way_line[hit_id] : refill_line;
    assign store_line = merge_store(base_line, word_sel, req_wstrb, req_wdata);

    always_comb begin
        for (int i = 0; i < WAY_NUM; i++) begin
            way_we[i] = (state == ST_LOOKUP && req_op == OP_WRITE && way_hit[i]) ||
                        (refill_done && rr_ptr == i[WAY_ID_WIDTH-1:0]);
        end
    end

    assign wr_index = req_addr.f.index;
    assign wr_tag   = req_addr.f.tag;
    assign wr_line  = (req_op == OP_WRITE) ? store_line : base_line;
    assign wr_dirty = (req_op == OP_WRITE);

    assign ready = (state == ST_IDLE) ||
                   (state == ST_LOOKUP && hit_any && req_op == OP_READ);

    assign data_ok = (state == ST_LOOKUP && hit_any) || refill_done;
    assign rdata   = base_line[word_sel*32 +: 32];

    assign rd_req  = (state == ST_REFILL) && !rd_sent;
    assign rd_addr = {req_addr.f.tag, req_addr.f.index, {OFFSET_WIDTH{1'b0}}};
    assign wr_req  = (state == ST_REPLACE);
    assign wr_addr = {victim_tag, req_addr.f.index, {OFFSET_WIDTH{1'b0}}};
    assign wr_data = victim_line;

endmodule

// ==== src/dcache_top.sv ====
module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  valid,
    input  logic                  op,
    input  cache_addr_t           addr,
    input  logic [3:0]            wstrb,
    input  logic [31:0]           wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [31:0]           rdata,

    output logic                  rd_req,
    output logic [31:0]           rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  logic [31:0]           ret_data,
    output logic                  wr_req,
    output logic [31:0]           wr_addr,
    output logic [LINE_WIDTH-1:0] wr_data,
    input  logic                  wr_rdy
);

    logic [INDEX_WIDTH-1:0] way_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;
    logic                   lookup_valid;
    logic                   req_op;
    cache_addr_t            req_addr;
    logic [3:0]             req_wstrb;
    logic [31:0]            req_wdata;
    logic                   ready;

    logic [WAY_NUM-1:0]     way_hit;
    logic [LINE_WIDTH-1:0]  way_line [WAY_NUM];
    logic [TAG_WIDTH-1:0]   way_tag  [WAY_NUM];
    logic [WAY_NUM-1:0]     way_dirty;
    logic [WAY_NUM-1:0]     way_we;
    logic [INDEX_WIDTH-1:0] wr_index;
    logic [TAG_WIDTH-1:0]   wr_tag;
    logic [LINE_WIDTH-1:0]  wr_line;
    logic                   wr_dirty;

    dcache_req_stage i_req_stage (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .op           (op),
        .addr         (addr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .ready        (ready),
        .addr_ok      (addr_ok),
        .way_index    (way_index),
        .way_tag      (lookup_tag),
        .lookup_valid (lookup_valid),
        .req_op       (req_op),
        .req_addr     (req_addr),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata)
    );

    for (genvar i = 0; i < WAY_NUM; i++) begin : g_way
        dcache_way i_way (
            .clk      (clk),
            .resetn   (resetn),
            .rd_index (way_index),
            .cmp_tag  (lookup_tag),
            .hit      (way_hit[i]),
            .rd_line  (way_line[i]),
            .rd_tag   (way_tag[i]),
            .rd_dirty (way_dirty[i]),
            .we       (way_we[i]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .wr_line  (wr_line),
            .wr_dirty (wr_dirty)
        );
    end

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_valid (lookup_valid),
        .req_op       (req_op),
        .req_addr     (req_addr),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata),
        .ready        (ready),
        .way_hit      (way_hit),
        .way_line     (way_line),
        .way_tag      (way_tag),
        .way_dirty    (way_dirty),
        .way_we       (way_we),
        .wr_index     (wr_index),
        .wr_tag       (wr_tag),
        .wr_line      (wr_line),
        .wr_dirty     (wr_dirty),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy)
    );

endmodule

// ==== bench/dcache_props.sv ====
module dcache_props
    import dcache_pkg::*;
(
    input logic                  clk,
    input logic                  resetn,
    input logic                  lookup_valid,
    input logic                  data_ok,
    input logic                  rd_req,
    input logic [31:0]           rd_addr,
    input logic                  rd_rdy,
    input logic                  wr_req,
    input logic [31:0]           wr_addr,
    input logic [LINE_WIDTH-1:0] wr_data,
    input logic                  wr_rdy
);

    logic busy;

    // a request is outstanding from its lookup until its data_ok
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
        end else if (data_ok) begin
            busy <= 1'b0;
        end else if (lookup_valid) begin
            busy <= 1'b1;
        end
    end

    // read request held until rd_rdy
    rd_req_held: assert property (
        @(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr)
    ) else $error("rd_req or rd_addr changed before rd_rdy");

    wr_req_held: assert property (
        @(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data)
    ) else $error("wr_req, wr_addr or wr_data changed before wr_rdy");

    // one completion per lookup
    no_done_in_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        data_ok |-> lookup_valid || busy
    ) else $error("data_ok high with no request outstanding");

endmodule

bind dcache_ctrl dcache_props i_props (
    .clk          (clk),
    .resetn       (resetn),
    .lookup_valid (lookup_valid),
    .data_ok      (data_ok),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .rd_rdy       (rd_rdy),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_rdy       (wr_rdy)
);

// ==== bench/dcache_tb.sv ====
module dcache_tb
    import dcache_pkg::*;
();

    localparam logic [31:0] NO_WB = 32'hffff_ffff;

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        hit;
        logic [31:0] wb_addr;
    } req_entry_t;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  valid;
    logic                  op;
    cache_addr_t           addr;
    logic [3:0]            wstrb;
    logic [31:0]           wdata;
    logic                  addr_ok;
    logic                  data_ok;
    logic [31:0]           rdata;
    logic                  rd_req;
    logic [31:0]           rd_addr;
    logic                  rd_rdy;
    logic                  ret_valid;
    logic                  ret_last;
    logic [31:0]           ret_data;
    logic                  wr_req;
    logic [31:0]           wr_addr;
    logic [LINE_WIDTH-1:0] wr_data;
    logic                  wr_rdy;

    req_entry_t  tests[$];
    logic [31:0] mem [1024];
    logic [31:0] lfsr_state = 32'hf139;
    logic [31:0] last_wb_addr;
    int          errors = 0;
    int          wb_count = 0;
    int          refill_count = 0;
    int          done_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #5 clk = ~clk;

    dcache_top i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic int unsigned random_bits(input int n);
        int unsigned r;
        logic        fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    // memory contents before any write-back
    function automatic logic [31:0] pattern(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'ha5a5a5a5;
    endfunction

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old,
        input logic [3:0]  strb,
        input logic [31:0] data
    );
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare_word(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_entry(
        input logic        e_op,
        input logic [31:0] e_addr,
        input logic [3:0]  e_strb,
        input logic [31:0] e_wdata,
        input logic [31:0] e_rdata,
        input logic        e_hit,
        input logic [31:0] e_wb_addr
    );
        req_entry_t e;
        e.op      = e_op;
        e.addr    = e_addr;
        e.strb    = e_strb;
        e.wdata   = e_wdata;
        e.rdata   = e_rdata;
        e.hit     = e_hit;
        e.wb_addr = e_wb_addr;
        tests.push_back(e);
    endtask

    task automatic check_quiet(input string when);
        compare_word({when, " data_ok"}, 32'h0, 32'(data_ok));
        compare_word({when, " rd_req"}, 32'h0, 32'(rd_req));
        compare_word({when, " wr_req"}, 32'h0, 32'(wr_req));
    endtask

    task automatic run_request(input int n);
        int lat;
        int wb_before;
        int refill_before;
        @(negedge clk);
        valid     = 1'b1;
        op        = tests[n].op;
        addr.word = tests[n].addr;
        wstrb     = tests[n].strb;
        wdata     = tests[n].wdata;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        wb_before     = wb_count;
        refill_before = refill_count;
        @(negedge clk);
        valid = 1'b0;
        lat   = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        if (tests[n].op == OP_READ) begin
            compare_word($sformatf("req %0d rdata", n), tests[n].rdata, rdata);
        end
        if (tests[n].hit) begin
            compare_word($sformatf("req %0d hit latency", n), 32'd1, lat);
        end
        compare_word($sformatf("req %0d refills", n), 32'(!tests[n].hit),
                     refill_count - refill_before);
        compare_word($sformatf("req %0d write-backs", n), 32'(tests[n].wb_addr != NO_WB),
                     wb_count - wb_before);
        if (tests[n].wb_addr != NO_WB) begin
            compare_word($sformatf("req %0d wb addr", n), tests[n].wb_addr, last_wb_addr);
        end
    endtask

    // read side of the memory model
    initial begin : read_model
        logic [9:0] base;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (rd_req) begin
                base = rd_addr[11:2];
                repeat (random_bits(2)) @(negedge clk);
                @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                refill_count++;
                for (int k = 0; k < WORDS_PER_LINE; k++) begin
                    // gap before each beat
                    repeat (random_bits(2)) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (k == WORDS_PER_LINE - 1);
                    ret_data  = mem[base + 10'(k)];
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    // write side records the evicted line
    initial begin : write_model
        logic [9:0] base;
        wr_rdy = 1'b0;
        forever begin
            @(posedge clk);
            if (wr_req) begin
                repeat (random_bits(2)) @(negedge clk);
                @(negedge clk);
                wr_rdy = 1'b1;
                @(posedge clk);
                base = wr_addr[11:2];
                for (int k = 0; k < WORDS_PER_LINE; k++) begin
                    mem[base + 10'(k)] = wr_data[k*32 +: 32];
                end
                last_wb_addr = wr_addr;
                wb_count++;
                @(negedge clk);
                wr_rdy = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (resetn && data_ok) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, a request never completed (%0d errors)",
                     cycle_count, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] m144;
        logic [31:0] m248;
        logic [31:0] m564;
        m144 = merge_bytes(pattern(32'h144), 4'b0011, 32'h1234_5678);
        m248 = merge_bytes(pattern(32'h248), 4'b1100, 32'hdead_beef);
        m564 = merge_bytes(pattern(32'h564), 4'b0100, 32'h00ab_0000);

        // set 4 gets tags 1, 2 and 3
        // set 6 gets one written line
        add_entry(OP_READ,  32'h140, 4'h0, 32'h0, pattern(32'h140), 1'b0, NO_WB);
        add_entry(OP_READ,  32'h144, 4'h0, 32'h0, pattern(32'h144), 1'b1, NO_WB);
        add_entry(OP_READ,  32'h148, 4'h0, 32'h0, pattern(32'h148), 1'b1, NO_WB);
        add_entry(OP_READ,  32'h14c, 4'h0, 32'h0, pattern(32'h14c), 1'b1, NO_WB);
        add_entry(OP_WRITE, 32'h144, 4'b0011, 32'h1234_5678, 32'h0, 1'b1, NO_WB);
        add_entry(OP_READ,  32'h144, 4'h0, 32'h0, m144, 1'b1, NO_WB);
        add_entry(OP_WRITE, 32'h248, 4'b1100, 32'hdead_beef, 32'h0, 1'b0, NO_WB);
        add_entry(OP_READ,  32'h248, 4'h0, 32'h0, m248, 1'b1, NO_WB);
        add_entry(OP_READ,  32'h340, 4'h0, 32'h0, pattern(32'h340), 1'b0, 32'h140);
        add_entry(OP_READ,  32'h144, 4'h0, 32'h0, m144, 1'b0, 32'h240);
        add_entry(OP_READ,  32'h248, 4'h0, 32'h0, m248, 1'b0, NO_WB);
        add_entry(OP_WRITE, 32'h560, 4'hf, 32'hcafe_f00d, 32'h0, 1'b0, NO_WB);
        add_entry(OP_WRITE, 32'h564, 4'b0100, 32'h00ab_0000, 32'h0, 1'b1, NO_WB);
        add_entry(OP_READ,  32'h560, 4'h0, 32'h0, 32'hcafe_f00d, 1'b1, NO_WB);
        add_entry(OP_READ,  32'h564, 4'h0, 32'h0, m564, 1'b1, NO_WB);
        add_entry(OP_READ,  32'h14c, 4'h0, 32'h0, pattern(32'h14c), 1'b1, NO_WB);
        cycle_limit = 300 * tests.size();

        for (int i = 0; i < 1024; i++) begin
            mem[i] = pattern(i * 4);
        end

        resetn    = 1'b0;
        valid     = 1'b0;
        op        = OP_READ;
        addr.word = '0;
        wstrb     = '0;
        wdata     = '0;
        repeat (8) begin
            @(negedge clk);
            check_quiet("in reset");
        end
        resetn = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_quiet("after reset");
        end

        for (int n = 0; n < tests.size(); n++) begin
            run_request(n);
        end

        repeat (4) @(posedge clk);
        compare_word("data_ok count", 32'(tests.size()), 32'(done_count));
        $display("%0d requests, %0d errors", tests.size(), errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/dcache_pkg.sv
src/dcache_req_stage.sv
src/dcache_way.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_props.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -- '>>> FAIL' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
